//--- design/ps2_pkg.sv
package ps2_pkg;

    localparam int frame_bits = 11;  // start, 8 data, odd parity, stop

    typedef logic [7:0] scan_t;

    localparam scan_t code_break = 8'hF0;  // release prefix
    localparam scan_t code_ext   = 8'hE0;  // extended prefix

    // make codes of the note keys, same order as tone_pkg::note_hz
    localparam scan_t key_codes [33] = '{
        8'h15,  // q
        8'h1D,  // w
        8'h24,  // e
        8'h2D,  // r
        8'h2C,  // t
        8'h35,  // y
        8'h3C,  // u
        8'h43,  // i
        8'h44,  // o
        8'h4D,  // p
        8'h54,  // [
        8'h5B,  // ]
        8'h1C,  // a
        8'h1B,  // s
        8'h23,  // d
        8'h2B,  // f
        8'h34,  // g
        8'h33,  // h
        8'h3B,  // j
        8'h42,  // k
        8'h4B,  // l
        8'h4C,  // ;
        8'h52,  // '
        8'h1A,  // z
        8'h22,  // x
        8'h21,  // c
        8'h2A,  // v
        8'h32,  // b
        8'h31,  // n
        8'h3A,  // m
        8'h41,  // ,
        8'h49,  // .
        8'h4A   // /
    };

endpackage

//--- design/tone_pkg.sv
package tone_pkg;

    localparam int sys_clk_hz = 50_000_000;

    localparam int half_period_w = 17;  // holds 95418 for the lowest note

    typedef logic [half_period_w-1:0] half_period_t;

    // note frequencies in Hz, indexed like ps2_pkg::key_codes
    localparam int note_hz [33] = '{
        262,   // low octave
        277,
        294,
        311,
        330,
        349,
        370,
        392,
        415,
        440,
        466,
        494,
        523,   // middle octave
        554,
        587,
        622,
        659,
        698,
        740,
        784,
        831,
        880,
        932,
        1047,  // high octave
        1109,
        1175,
        1245,
        1319,
        1397,
        1480,
        1568,
        1661,
        1760
    };

endpackage

//--- design/ps2_rx.sv
`timescale 1ns/1ps

module ps2_rx (
    input  logic           sys_clk,
    input  logic           sys_rst_n,
    input  logic           ps2_clk,
    input  logic           ps2_data,
    output ps2_pkg::scan_t scan_code,
    output logic           byte_valid,
    output logic           frame_err
);

    localparam int cnt_w = $clog2(ps2_pkg::frame_bits);

    logic [1:0]                     clk_sync;
    logic [1:0]                     data_sync;
    logic                           clk_prev;
    logic                           clk_fall;
    logic                           sample_en;
    logic [cnt_w-1:0]               bit_cnt;
    logic [ps2_pkg::frame_bits-1:0] shift_reg;
    logic [ps2_pkg::frame_bits-1:0] frame;
    logic                           last_bit;
    logic                           frame_ok;

    // both lines idle high, open collector
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            clk_sync  <= 2'b11;
            data_sync <= 2'b11;
            clk_prev  <= 1'b1;
            sample_en <= 1'b0;
        end else begin
            clk_sync  <= {clk_sync[0], ps2_clk};
            data_sync <= {data_sync[0], ps2_data};
            clk_prev  <= clk_sync[1];
            sample_en <= clk_fall;  // sample one cycle after the edge
        end
    end

    assign clk_fall = clk_prev & ~clk_sync[1];

    // lsb first, so the newest bit enters at the top
    assign frame    = {data_sync[1], shift_reg[ps2_pkg::frame_bits-1:1]};
    assign last_bit = sample_en && (int'(bit_cnt) == ps2_pkg::frame_bits - 1);
    assign frame_ok = !frame[0]                                    // start
                      && (^frame[ps2_pkg::frame_bits-2:1])         // odd parity
                      && frame[ps2_pkg::frame_bits-1];             // stop

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            bit_cnt <= '0;
        end else if (sample_en) begin
            if (last_bit) begin
                bit_cnt <= '0;
            end else begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge sys_clk) begin
        if (sample_en) begin
            shift_reg <= frame;
        end
        if (last_bit && frame_ok) begin
            scan_code <= frame[8:1];
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            byte_valid <= 1'b0;
            frame_err  <= 1'b0;
        end else begin
            byte_valid <= last_bit && frame_ok;
            frame_err  <= last_bit && !frame_ok;
        end
    end

endmodule

//--- design/key_tracker.sv
`timescale 1ns/1ps

module key_tracker (
    input  logic           sys_clk,
    input  logic           sys_rst_n,
    input  ps2_pkg::scan_t scan_code,
    input  logic           byte_valid,
    output logic [15:0]    rec_data
);

    typedef enum logic [1:0] {
        st_idle,
        st_brk,
        st_ext,
        st_ext_brk
    } state_t;

    state_t state;

    // rec_data holds {previous byte, held key}
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            state    <= st_idle;
            rec_data <= '0;
        end else if (byte_valid) begin
            case (state)
                st_idle: begin
                    if (scan_code == ps2_pkg::code_break) begin
                        state <= st_brk;
                    end else if (scan_code == ps2_pkg::code_ext) begin
                        state <= st_ext;
                    end else begin
                        rec_data <= {rec_data[7:0], scan_code};  // new key wins
                    end
                end
                st_brk: begin
                    state <= st_idle;
                    if (scan_code == rec_data[7:0]) begin
                        rec_data <= '0;  // held key let go
                    end
                end
                st_ext: begin
                    // extended key ignored, but watch for its release
                    if (scan_code == ps2_pkg::code_break) begin
                        state <= st_ext_brk;
                    end else begin
                        state <= st_idle;
                    end
                end
                st_ext_brk: begin
                    state <= st_idle;  // drop the extended release code
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

endmodule

//--- design/freq_ctrl.sv
`timescale 1ns/1ps

module freq_ctrl (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  logic [15:0]            rec_data,
    output tone_pkg::half_period_t cnt_freq
);

    tone_pkg::half_period_t cnt_next;
    logic                   hit;

    // table search over the note keys, zero when nothing matches
    always_comb begin
        cnt_next = '0;
        hit      = 1'b0;
        for (int i = 0; i < $size(ps2_pkg::key_codes); i++) begin
            if (!hit && rec_data[7:0] == ps2_pkg::key_codes[i]) begin
                hit      = 1'b1;
                cnt_next = tone_pkg::half_period_t'(
                    tone_pkg::sys_clk_hz / (2 * tone_pkg::note_hz[i]) - 1);
            end
        end
    end

    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_freq <= '0;
        end else begin
            cnt_freq <= cnt_next;
        end
    end

endmodule

//--- design/tone_gen.sv
`timescale 1ns/1ps

module tone_gen (
    input  logic                   sys_clk,
    input  logic                   sys_rst_n,
    input  tone_pkg::half_period_t cnt_freq,
    output logic                   buzzer
);

    tone_pkg::half_period_t cnt_last;
    tone_pkg::half_period_t half_cnt;

    // each phase lasts cnt_freq+1 cycles
    always_ff @(posedge sys_clk or negedge sys_rst_n) begin
        if (!sys_rst_n) begin
            cnt_last <= '0;
            half_cnt <= '0;
            buzzer   <= 1'b0;
        end else if (cnt_freq != cnt_last) begin
            cnt_last <= cnt_freq;  // new note, restart low phase
            half_cnt <= cnt_freq;
            buzzer   <= 1'b0;
        end else if (cnt_freq == '0) begin
            half_cnt <= '0;
            buzzer   <= 1'b0;  // silence
        end else if (half_cnt == '0) begin
            half_cnt <= cnt_freq;
            buzzer   <= ~buzzer;
        end else begin
            half_cnt <= half_cnt - 1'b1;
        end
    end

endmodule

//--- design/ps2_piano.sv
`timescale 1ns/1ps

module ps2_piano (
    input  logic sys_clk,
    input  logic sys_rst_n,
    input  logic ps2_clk,
    input  logic ps2_data,
    output logic buzzer,
    output logic frame_err
);

    ps2_pkg::scan_t         scan_code;
    logic                   byte_valid;
    logic [15:0]            rec_data;
    tone_pkg::half_period_t cnt_freq;

    ps2_rx i_ps2_rx (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .ps2_clk    (ps2_clk),
        .ps2_data   (ps2_data),
        .scan_code  (scan_code),
        .byte_valid (byte_valid),
        .frame_err  (frame_err)
    );

    key_tracker i_key_tracker (
        .sys_clk    (sys_clk),
        .sys_rst_n  (sys_rst_n),
        .scan_code  (scan_code),
        .byte_valid (byte_valid),
        .rec_data   (rec_data)
    );

    freq_ctrl i_freq_ctrl (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .rec_data  (rec_data),
        .cnt_freq  (cnt_freq)
    );

    tone_gen i_tone_gen (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .cnt_freq  (cnt_freq),
        .buzzer    (buzzer)
    );

endmodule

//--- tests/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic sys_clk
);

    initial begin
        sys_clk = 1'b0;
    end

    always #2 sys_clk = ~sys_clk;  // 4 ns period

endmodule

//--- tests/ps2_piano_asserts.sv
`timescale 1ns/1ps

module ps2_piano_asserts (
    input logic                   sys_clk,
    input logic                   sys_rst_n,
    input logic                   byte_valid,
    input logic                   frame_err,
    input tone_pkg::half_period_t cnt_freq,
    input logic                   buzzer
);

    valid_one_cycle: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        byte_valid |=> !byte_valid
    ) else $error("byte_valid high for more than one cycle");

    // tone_gen needs one cycle to drop the buzzer after the count goes to zero
    silent_on_zero: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        (cnt_freq == '0 && $past(cnt_freq) == '0) |-> !buzzer
    ) else $error("buzzer high while cnt_freq is zero");

    err_or_valid: assert property (
        @(posedge sys_clk) disable iff (!sys_rst_n)
        !(frame_err && byte_valid)
    ) else $error("frame_err and byte_valid high together");

endmodule

bind ps2_piano ps2_piano_asserts i_ps2_piano_asserts (
    .sys_clk    (sys_clk),
    .sys_rst_n  (sys_rst_n),
    .byte_valid (byte_valid),
    .frame_err  (frame_err),
    .cnt_freq   (cnt_freq),
    .buzzer     (buzzer)
);

//--- tests/tb_ps2_piano.sv
`timescale 1ns/1ps

module tb_ps2_piano;

    localparam int half_bit       = 10;  // 20 cycles per ps2 bit
    localparam int idle_cycles    = 40;
    localparam int frame_cycles   = ps2_pkg::frame_bits * 2 * half_bit + idle_cycles;
    localparam int longest_phase  = tone_pkg::sys_clk_hz / (2 * tone_pkg::note_hz[0]);
    localparam int phase_limit    = 3 * longest_phase;
    localparam int silence_cycles = 30000;  // longer than any high octave phase
    localparam int n_frames       = 24;
    localparam int n_measures     = 14;
    localparam int n_windows      = 2;
    localparam int watchdog_cycles =
        2 * (n_frames * frame_cycles + n_measures * phase_limit
             + n_windows * silence_cycles) + 10;

    localparam ps2_pkg::scan_t unmapped_code = 8'h29;  // space bar
    localparam ps2_pkg::scan_t ext_key       = 8'h4A;  // keypad slash after E0

    logic   sys_clk;
    logic   sys_rst_n;
    logic   ps2_clk;
    logic   ps2_data;
    logic   buzzer;
    logic   frame_err;
    integer seed;
    string  test_name;
    int     value_errors;
    int     other_errors;
    int     err_pulses = 0;

    tb_clock i_tb_clock (
        .sys_clk (sys_clk)
    );

    ps2_piano i_ps2_piano (
        .sys_clk   (sys_clk),
        .sys_rst_n (sys_rst_n),
        .ps2_clk   (ps2_clk),
        .ps2_data  (ps2_data),
        .buzzer    (buzzer),
        .frame_err (frame_err)
    );

    always @(negedge sys_clk) begin
        if (frame_err === 1'b1) begin
            err_pulses++;
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge sys_clk);
        #1;
    endtask

    // start, 8 data lsb first, odd parity, stop
    task automatic send_byte(input ps2_pkg::scan_t code, input logic bad_parity);
        logic [ps2_pkg::frame_bits-1:0] bits;
        logic                           parity;
        int                             i;
        parity = ~^code;
        if (bad_parity) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, code, 1'b0};
        for (i = 0; i < ps2_pkg::frame_bits; i++) begin
            ps2_data = bits[i];
            wait_cycles(half_bit);
            ps2_clk = 1'b0;  // device shifts on the falling edge
            wait_cycles(half_bit);
            ps2_clk = 1'b1;
        end
        ps2_data = 1'b1;
        wait_cycles(idle_cycles);
    endtask

    function automatic tone_pkg::half_period_t expected_phase(input int idx);
        int count;
        count = tone_pkg::sys_clk_hz / (2 * tone_pkg::note_hz[idx]) - 1;
        return tone_pkg::half_period_t'(count + 1);
    endfunction

    task automatic compare_period(input string name, input tone_pkg::half_period_t expected,
                                  input tone_pkg::half_period_t actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %0d, actual %0d", name, expected, actual);
            value_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic expected, input logic actual);
        if (expected !== actual) begin
            $display("ERR %s: expected %b, actual %b", name, expected, actual);
            value_errors++;
        end
    endtask

    // one full high phase, sampled on the falling clock edge
    task automatic measure_phase(output tone_pkg::half_period_t len, output logic ok);
        int waited;
        int count;
        waited = 0;
        count  = 0;
        @(negedge sys_clk);
        while (buzzer !== 1'b0 && waited < phase_limit) begin
            @(negedge sys_clk);
            waited++;
        end
        while (buzzer !== 1'b1 && waited < phase_limit) begin
            @(negedge sys_clk);
            waited++;
        end
        while (buzzer === 1'b1 && waited < phase_limit) begin
            count++;
            @(negedge sys_clk);
            waited++;
        end
        ok  = (waited < phase_limit);
        len = tone_pkg::half_period_t'(count);
        if (!ok) begin
            $display("%s: buzzer did not complete a high phase within %0d cycles",
                     test_name, phase_limit);
            other_errors++;
        end
    endtask

    task automatic check_note(input int idx);
        tone_pkg::half_period_t len;
        logic                   ok;
        measure_phase(len, ok);
        if (ok) begin
            compare_period(test_name, expected_phase(idx), len);
        end
    endtask

    task automatic check_silent();
        logic seen_high;
        seen_high = 1'b0;
        repeat (silence_cycles) begin
            @(negedge sys_clk);
            if (buzzer !== 1'b0) begin
                seen_high = 1'b1;
            end
        end
        compare_flag(test_name, 1'b0, seen_high);
    endtask

    task automatic press_and_check(input int idx);
        send_byte(ps2_pkg::key_codes[idx], 1'b0);
        check_note(idx);
    endtask

    task automatic test_press();
        int idx;
        int pulses_before;
        test_name     = "press";
        pulses_before = err_pulses;
        idx           = 23 + int'($unsigned($random(seed)) % 32'd10);  // high octave
        press_and_check(23);
        press_and_check(27);
        press_and_check(32);
        press_and_check(idx);
        compare_flag("press frame_err", 1'b0, err_pulses != pulses_before);
    endtask

    task automatic test_switch();
        test_name = "switch";
        press_and_check(24);
        press_and_check(30);  // no release in between
    endtask

    task automatic test_release();
        test_name = "release";
        send_byte(ps2_pkg::key_codes[25], 1'b0);
        press_and_check(29);
        send_byte(ps2_pkg::code_break, 1'b0);
        send_byte(ps2_pkg::key_codes[25], 1'b0);
        check_note(29);  // other key let go, note stays
        send_byte(ps2_pkg::code_break, 1'b0);
        send_byte(ps2_pkg::key_codes[29], 1'b0);
        check_silent();
    endtask

    task automatic test_ignore();
        test_name = "ignore";
        press_and_check(26);
        send_byte(ps2_pkg::code_ext, 1'b0);
        send_byte(ext_key, 1'b0);
        check_note(26);
        send_byte(ps2_pkg::code_ext, 1'b0);
        send_byte(ps2_pkg::code_break, 1'b0);
        send_byte(ext_key, 1'b0);
        check_note(26);
        send_byte(unmapped_code, 1'b0);
        check_silent();
    endtask

    task automatic test_parity();
        int pulses_before;
        test_name = "parity";
        press_and_check(28);
        pulses_before = err_pulses;
        send_byte(ps2_pkg::key_codes[31], 1'b1);
        compare_flag("parity frame_err", 1'b1, err_pulses != pulses_before);
        check_note(28);  // old note keeps playing
    endtask

    initial begin
        seed         = 32'h74aac5ce;
        value_errors = 0;
        other_errors = 0;
        test_name    = "reset";
        sys_rst_n    = 1'b0;
        ps2_clk      = 1'b1;
        ps2_data     = 1'b1;
        wait_cycles(10);
        sys_rst_n = 1'b1;
        wait_cycles(5);
        compare_flag("reset buzzer", 1'b0, buzzer);
        compare_flag("reset frame_err", 1'b0, frame_err);
        test_press();
        test_switch();
        test_release();
        test_ignore();
        test_parity();
        $display("errors: %0d value mismatches, %0d other failures",
                 value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        repeat (watchdog_cycles) @(posedge sys_clk);
        $display("watchdog: run did not finish within %0d cycles", watchdog_cycles);
        $display("Done: errors found");
        $finish;
    end

endmodule

//--- list.f
design/ps2_pkg.sv
design/tone_pkg.sv
design/ps2_rx.sv
design/key_tracker.sv
design/freq_ctrl.sv
design/tone_gen.sv
design/ps2_piano.sv
tests/tb_clock.sv
tests/ps2_piano_asserts.sv
tests/tb_ps2_piano.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the ps2_piano testbench with Verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_ps2_piano \
    -Mdir obj_dir -o sim_ps2_piano
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/sim_ps2_piano > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Done: errors found" "$log"; then
    echo "FAIL"
    exit 1
fi
if ! grep -q "^Done: no errors$" "$log"; then
    echo "FAIL: closing line missing"
    exit 1
fi
echo "PASS"
exit 0
